//--- common/axi_pkg.sv
package axi_pkg;

    // Channel widths of the AXI buses on both sides of the bridge
    localparam int AXI_ADDR_WIDTH  = 32;
    localparam int AXI_DATA_WIDTH  = 32;
    localparam int AXI_ID_WIDTH    = 8;
    localparam int AXI_LEN_WIDTH   = 8;
    localparam int AXI_SIZE_WIDTH  = 3;
    localparam int AXI_BURST_WIDTH = 2;
    localparam int AXI_RESP_WIDTH  = 2;

    // Read response codes
    localparam logic [AXI_RESP_WIDTH-1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [AXI_RESP_WIDTH-1:0] AXI_RESP_DECERR = 2'b11;

endpackage

//--- common/mmu_pkg.sv
package mmu_pkg;

    import axi_pkg::*;

    // Request word to the MMU with the virtual address in the low bits
    localparam int MMU_REQ_PAD_WIDTH = 5;
    localparam int MMU_REQ_ID_LSB    = AXI_ADDR_WIDTH;
    localparam int MMU_REQ_LEN_LSB   = MMU_REQ_ID_LSB + AXI_ID_WIDTH;
    localparam int MMU_REQ_SIZE_LSB  = MMU_REQ_LEN_LSB + AXI_LEN_WIDTH;
    localparam int MMU_REQ_WIDTH     = MMU_REQ_SIZE_LSB + AXI_SIZE_WIDTH + MMU_REQ_PAD_WIDTH;

    // Response word from the MMU
    // A set drop flag means the read is refused, otherwise the low bits
    // carry the physical address
    localparam int MMU_RSP_PAD_WIDTH = 7;
    localparam int MMU_RSP_DROP_BIT  = AXI_ADDR_WIDTH;
    localparam int MMU_RSP_WIDTH     = AXI_ADDR_WIDTH + 1 + MMU_RSP_PAD_WIDTH;

endpackage

//--- ar_path/ar_request_fifo.sv
`timescale 1ns/1ps

module ar_request_fifo #(
    parameter int AR_FIFO_DEPTH = 8
) (
    input  logic                                  s_axi_clk,
    input  logic                                  s_aresetn,

    input  logic [axi_pkg::AXI_ID_WIDTH-1:0]      s_axi_arid,
    input  logic [axi_pkg::AXI_ADDR_WIDTH-1:0]    s_axi_araddr,
    input  logic [axi_pkg::AXI_LEN_WIDTH-1:0]     s_axi_arlen,
    input  logic [axi_pkg::AXI_SIZE_WIDTH-1:0]    s_axi_arsize,
    input  logic [axi_pkg::AXI_BURST_WIDTH-1:0]   s_axi_arburst,
    input  logic                                  s_axi_arvalid,
    output logic                                  s_axi_arready,

    output logic [axi_pkg::AXI_ID_WIDTH-1:0]      head_id,
    output logic [axi_pkg::AXI_ADDR_WIDTH-1:0]    head_addr,
    output logic [axi_pkg::AXI_LEN_WIDTH-1:0]     head_len,
    output logic [axi_pkg::AXI_SIZE_WIDTH-1:0]    head_size,
    output logic [axi_pkg::AXI_BURST_WIDTH-1:0]   head_burst,
    output logic                                  fifo_empty,
    input  logic                                  fifo_pop
);

    import axi_pkg::*;

    localparam int PTR_WIDTH   = $clog2(AR_FIFO_DEPTH);
    localparam int ENTRY_WIDTH = AXI_ID_WIDTH + AXI_ADDR_WIDTH + AXI_LEN_WIDTH
                               + AXI_SIZE_WIDTH + AXI_BURST_WIDTH;

    logic [ENTRY_WIDTH-1:0] entries [AR_FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [PTR_WIDTH:0]     count;
    logic                   push;
    logic                   pop;

    assign s_axi_arready = (count != (PTR_WIDTH+1)'(AR_FIFO_DEPTH));
    assign fifo_empty    = (count == '0);
    assign push          = s_axi_arvalid & s_axi_arready;
    // A pop on an empty queue is ignored
    assign pop           = fifo_pop & ~fifo_empty;

    assign {head_id, head_addr, head_len, head_size, head_burst} = entries[rd_ptr];

    always_ff @(posedge s_axi_clk) begin
        if (push) begin
            entries[wr_ptr] <= {s_axi_arid, s_axi_araddr, s_axi_arlen,
                                s_axi_arsize, s_axi_arburst};
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge s_axi_clk) begin
        if (!s_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- ar_path/ar_translate_ctrl.sv
`timescale 1ns/1ps

module ar_translate_ctrl (
    input  logic                                  s_axi_clk,
    input  logic                                  s_aresetn,

    input  logic [axi_pkg::AXI_ID_WIDTH-1:0]      head_id,
    input  logic [axi_pkg::AXI_ADDR_WIDTH-1:0]    head_addr,
    input  logic [axi_pkg::AXI_LEN_WIDTH-1:0]     head_len,
    input  logic [axi_pkg::AXI_SIZE_WIDTH-1:0]    head_size,
    input  logic [axi_pkg::AXI_BURST_WIDTH-1:0]   head_burst,
    input  logic                                  fifo_empty,
    output logic                                  fifo_pop,

    output logic [mmu_pkg::MMU_REQ_WIDTH-1:0]     to_mmu_tdata,
    output logic                                  to_mmu_tvalid,
    input  logic                                  to_mmu_tready,
    input  logic [mmu_pkg::MMU_RSP_WIDTH-1:0]     from_mmu_tdata,
    input  logic                                  from_mmu_tvalid,
    output logic                                  from_mmu_tready,

    output logic [axi_pkg::AXI_ID_WIDTH-1:0]      m_axi_arid,
    output logic [axi_pkg::AXI_ADDR_WIDTH-1:0]    m_axi_araddr,
    output logic [axi_pkg::AXI_LEN_WIDTH-1:0]     m_axi_arlen,
    output logic [axi_pkg::AXI_SIZE_WIDTH-1:0]    m_axi_arsize,
    output logic [axi_pkg::AXI_BURST_WIDTH-1:0]   m_axi_arburst,
    output logic                                  m_axi_arvalid,
    input  logic                                  m_axi_arready,

    output logic                                  drop_start,
    output logic [axi_pkg::AXI_ID_WIDTH-1:0]      drop_id,
    output logic [axi_pkg::AXI_LEN_WIDTH-1:0]     drop_len,
    input  logic                                  burst_done
);

    import axi_pkg::*;
    import mmu_pkg::*;

    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_REQUEST   = 3'd1;
    localparam logic [2:0] ST_WAIT_RSP  = 3'd2;
    localparam logic [2:0] ST_ISSUE     = 3'd3;
    localparam logic [2:0] ST_WAIT_DATA = 3'd4;

    logic [2:0]                state;
    logic [AXI_ADDR_WIDTH-1:0] phys_addr;
    logic                      rsp_take;
    logic                      rsp_drop;

    // The head entry stays put until it is popped, so the request word
    // and the memory AR fields can be taken straight from it
    always_comb begin
        to_mmu_tdata = '0;
        to_mmu_tdata[AXI_ADDR_WIDTH-1:0]                 = head_addr;
        to_mmu_tdata[MMU_REQ_ID_LSB +: AXI_ID_WIDTH]     = head_id;
        to_mmu_tdata[MMU_REQ_LEN_LSB +: AXI_LEN_WIDTH]   = head_len;
        to_mmu_tdata[MMU_REQ_SIZE_LSB +: AXI_SIZE_WIDTH] = head_size;
    end

    assign to_mmu_tvalid   = (state == ST_REQUEST);
    assign from_mmu_tready = (state == ST_WAIT_RSP);
    assign rsp_take        = from_mmu_tvalid & from_mmu_tready;
    assign rsp_drop        = from_mmu_tdata[MMU_RSP_DROP_BIT];

    assign m_axi_arvalid = (state == ST_ISSUE);
    assign m_axi_araddr  = phys_addr;
    assign m_axi_arid    = head_id;
    assign m_axi_arlen   = head_len;
    assign m_axi_arsize  = head_size;
    assign m_axi_arburst = head_burst;

    assign drop_id  = head_id;
    assign drop_len = head_len;

    // The head leaves the queue once the memory has its read, or as soon
    // as a drop is handed over to the return block
    assign fifo_pop = (m_axi_arvalid & m_axi_arready) | drop_start;

    always_ff @(posedge s_axi_clk) begin
        if (rsp_take) begin
            phys_addr <= from_mmu_tdata[AXI_ADDR_WIDTH-1:0];
        end
    end

    always_ff @(posedge s_axi_clk) begin
        if (!s_aresetn) begin
            state      <= ST_IDLE;
            drop_start <= 1'b0;
        end else begin
            drop_start <= rsp_take & rsp_drop;
            case (state)
                ST_IDLE:      if (!fifo_empty) state <= ST_REQUEST;
                ST_REQUEST:   if (to_mmu_tready) state <= ST_WAIT_RSP;
                ST_WAIT_RSP: begin
                    if (rsp_take) begin
                        state <= rsp_drop ? ST_WAIT_DATA : ST_ISSUE;
                    end
                end
                ST_ISSUE:     if (m_axi_arready) state <= ST_WAIT_DATA;
                ST_WAIT_DATA: if (burst_done) state <= ST_IDLE;
                default:      state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/r_return.sv
`timescale 1ns/1ps

module r_return (
    input  logic                                  s_axi_clk,
    input  logic                                  s_aresetn,

    input  logic [axi_pkg::AXI_ID_WIDTH-1:0]      m_axi_rid,
    input  logic [axi_pkg::AXI_DATA_WIDTH-1:0]    m_axi_rdata,
    input  logic [axi_pkg::AXI_RESP_WIDTH-1:0]    m_axi_rresp,
    input  logic                                  m_axi_rlast,
    input  logic                                  m_axi_rvalid,
    output logic                                  m_axi_rready,

    output logic [axi_pkg::AXI_ID_WIDTH-1:0]      s_axi_rid,
    output logic [axi_pkg::AXI_DATA_WIDTH-1:0]    s_axi_rdata,
    output logic [axi_pkg::AXI_RESP_WIDTH-1:0]    s_axi_rresp,
    output logic                                  s_axi_rlast,
    output logic                                  s_axi_rvalid,
    input  logic                                  s_axi_rready,

    input  logic                                  drop_start,
    input  logic [axi_pkg::AXI_ID_WIDTH-1:0]      drop_id,
    input  logic [axi_pkg::AXI_LEN_WIDTH-1:0]     drop_len,
    output logic                                  burst_done
);

    import axi_pkg::*;

    logic                     drop_mode;
    // Beats still to send after the current one
    logic [AXI_LEN_WIDTH-1:0] beats_left;
    logic [AXI_ID_WIDTH-1:0]  drop_id_q;
    logic                     drop_last;

    assign drop_last = (beats_left == '0);

    // While dropping, the memory side is held off and the bridge makes
    // its own error beats
    always_comb begin
        if (drop_mode) begin
            s_axi_rid    = drop_id_q;
            s_axi_rdata  = '0;
            s_axi_rresp  = AXI_RESP_DECERR;
            s_axi_rlast  = drop_last;
            s_axi_rvalid = 1'b1;
            m_axi_rready = 1'b0;
        end else begin
            s_axi_rid    = m_axi_rid;
            s_axi_rdata  = m_axi_rdata;
            s_axi_rresp  = m_axi_rresp;
            s_axi_rlast  = m_axi_rlast;
            s_axi_rvalid = m_axi_rvalid;
            m_axi_rready = s_axi_rready;
        end
    end

    assign burst_done = s_axi_rvalid & s_axi_rready & s_axi_rlast;

    always_ff @(posedge s_axi_clk) begin
        if (drop_start) begin
            drop_id_q <= drop_id;
        end
    end

    always_ff @(posedge s_axi_clk) begin
        if (!s_aresetn) begin
            drop_mode  <= 1'b0;
            beats_left <= '0;
        end else if (drop_start) begin
            drop_mode  <= 1'b1;
            beats_left <= drop_len;
        end else if (drop_mode && s_axi_rready) begin
            // Step one beat per handshake and leave on the final one
            if (drop_last) begin
                drop_mode <= 1'b0;
            end else begin
                beats_left <= beats_left - 1'b1;
            end
        end
    end

endmodule

//--- hdl/axi_mmu_rd_top.sv
`timescale 1ns/1ps

module axi_mmu_rd_top #(
    parameter int AR_FIFO_DEPTH = 8
) (
    input  logic                                  s_axi_clk,
    input  logic                                  s_aresetn,

    input  logic [axi_pkg::AXI_ID_WIDTH-1:0]      s_axi_arid,
    input  logic [axi_pkg::AXI_ADDR_WIDTH-1:0]    s_axi_araddr,
    input  logic [axi_pkg::AXI_LEN_WIDTH-1:0]     s_axi_arlen,
    input  logic [axi_pkg::AXI_SIZE_WIDTH-1:0]    s_axi_arsize,
    input  logic [axi_pkg::AXI_BURST_WIDTH-1:0]   s_axi_arburst,
    input  logic                                  s_axi_arvalid,
    output logic                                  s_axi_arready,

    output logic [axi_pkg::AXI_ID_WIDTH-1:0]      s_axi_rid,
    output logic [axi_pkg::AXI_DATA_WIDTH-1:0]    s_axi_rdata,
    output logic [axi_pkg::AXI_RESP_WIDTH-1:0]    s_axi_rresp,
    output logic                                  s_axi_rlast,
    output logic                                  s_axi_rvalid,
    input  logic                                  s_axi_rready,

    output logic [axi_pkg::AXI_ID_WIDTH-1:0]      m_axi_arid,
    output logic [axi_pkg::AXI_ADDR_WIDTH-1:0]    m_axi_araddr,
    output logic [axi_pkg::AXI_LEN_WIDTH-1:0]     m_axi_arlen,
    output logic [axi_pkg::AXI_SIZE_WIDTH-1:0]    m_axi_arsize,
    output logic [axi_pkg::AXI_BURST_WIDTH-1:0]   m_axi_arburst,
    output logic                                  m_axi_arvalid,
    input  logic                                  m_axi_arready,

    input  logic [axi_pkg::AXI_ID_WIDTH-1:0]      m_axi_rid,
    input  logic [axi_pkg::AXI_DATA_WIDTH-1:0]    m_axi_rdata,
    input  logic [axi_pkg::AXI_RESP_WIDTH-1:0]    m_axi_rresp,
    input  logic                                  m_axi_rlast,
    input  logic                                  m_axi_rvalid,
    output logic                                  m_axi_rready,

    output logic [mmu_pkg::MMU_REQ_WIDTH-1:0]     to_mmu_tdata,
    output logic                                  to_mmu_tvalid,
    input  logic                                  to_mmu_tready,

    input  logic [mmu_pkg::MMU_RSP_WIDTH-1:0]     from_mmu_tdata,
    input  logic                                  from_mmu_tvalid,
    output logic                                  from_mmu_tready
);

    import axi_pkg::*;

    // Oldest pending read request
    logic [AXI_ID_WIDTH-1:0]    head_id;
    logic [AXI_ADDR_WIDTH-1:0]  head_addr;
    logic [AXI_LEN_WIDTH-1:0]   head_len;
    logic [AXI_SIZE_WIDTH-1:0]  head_size;
    logic [AXI_BURST_WIDTH-1:0] head_burst;
    logic                       fifo_empty;
    logic                       fifo_pop;

    logic                       drop_start;
    logic [AXI_ID_WIDTH-1:0]    drop_id;
    logic [AXI_LEN_WIDTH-1:0]   drop_len;
    logic                       burst_done;

    ar_request_fifo #(
        .AR_FIFO_DEPTH (AR_FIFO_DEPTH)
    ) u_ar_request_fifo (
        .s_axi_clk     (s_axi_clk),
        .s_aresetn     (s_aresetn),
        .s_axi_arid    (s_axi_arid),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arlen   (s_axi_arlen),
        .s_axi_arsize  (s_axi_arsize),
        .s_axi_arburst (s_axi_arburst),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .head_id       (head_id),
        .head_addr     (head_addr),
        .head_len      (head_len),
        .head_size     (head_size),
        .head_burst    (head_burst),
        .fifo_empty    (fifo_empty),
        .fifo_pop      (fifo_pop)
    );

    ar_translate_ctrl u_ar_translate_ctrl (
        .s_axi_clk       (s_axi_clk),
        .s_aresetn       (s_aresetn),
        .head_id         (head_id),
        .head_addr       (head_addr),
        .head_len        (head_len),
        .head_size       (head_size),
        .head_burst      (head_burst),
        .fifo_empty      (fifo_empty),
        .fifo_pop        (fifo_pop),
        .to_mmu_tdata    (to_mmu_tdata),
        .to_mmu_tvalid   (to_mmu_tvalid),
        .to_mmu_tready   (to_mmu_tready),
        .from_mmu_tdata  (from_mmu_tdata),
        .from_mmu_tvalid (from_mmu_tvalid),
        .from_mmu_tready (from_mmu_tready),
        .m_axi_arid      (m_axi_arid),
        .m_axi_araddr    (m_axi_araddr),
        .m_axi_arlen     (m_axi_arlen),
        .m_axi_arsize    (m_axi_arsize),
        .m_axi_arburst   (m_axi_arburst),
        .m_axi_arvalid   (m_axi_arvalid),
        .m_axi_arready   (m_axi_arready),
        .drop_start      (drop_start),
        .drop_id         (drop_id),
        .drop_len        (drop_len),
        .burst_done      (burst_done)
    );

    r_return u_r_return (
        .s_axi_clk    (s_axi_clk),
        .s_aresetn    (s_aresetn),
        .m_axi_rid    (m_axi_rid),
        .m_axi_rdata  (m_axi_rdata),
        .m_axi_rresp  (m_axi_rresp),
        .m_axi_rlast  (m_axi_rlast),
        .m_axi_rvalid (m_axi_rvalid),
        .m_axi_rready (m_axi_rready),
        .s_axi_rid    (s_axi_rid),
        .s_axi_rdata  (s_axi_rdata),
        .s_axi_rresp  (s_axi_rresp),
        .s_axi_rlast  (s_axi_rlast),
        .s_axi_rvalid (s_axi_rvalid),
        .s_axi_rready (s_axi_rready),
        .drop_start   (drop_start),
        .drop_id      (drop_id),
        .drop_len     (drop_len),
        .burst_done   (burst_done)
    );

endmodule

//--- sim/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

    // Read transactions in the order they are sent with one row per AR request
    localparam int NUM_VECS = 10;

    string                      vec_name  [NUM_VECS];
    logic [AXI_ID_WIDTH-1:0]    vec_id    [NUM_VECS];
    logic [AXI_ADDR_WIDTH-1:0]  vec_vaddr [NUM_VECS];
    logic [AXI_LEN_WIDTH-1:0]   vec_len   [NUM_VECS];
    logic [AXI_SIZE_WIDTH-1:0]  vec_size  [NUM_VECS];
    logic [AXI_BURST_WIDTH-1:0] vec_burst [NUM_VECS];
    logic                       vec_drop  [NUM_VECS];
    logic [AXI_ADDR_WIDTH-1:0]  vec_paddr [NUM_VECS];

    task automatic set_row(input int idx, input string name, input logic [31:0] id,
                           input logic [31:0] vaddr, input logic [31:0] len,
                           input logic [31:0] size, input logic [31:0] burst,
                           input logic [31:0] drop, input logic [31:0] paddr);
        vec_name[idx]  = name;
        vec_id[idx]    = id[AXI_ID_WIDTH-1:0];
        vec_vaddr[idx] = vaddr;
        vec_len[idx]   = len[AXI_LEN_WIDTH-1:0];
        vec_size[idx]  = size[AXI_SIZE_WIDTH-1:0];
        vec_burst[idx] = burst[AXI_BURST_WIDTH-1:0];
        vec_drop[idx]  = drop[0];
        vec_paddr[idx] = paddr;
    endtask

    task automatic load_table();
        // Name, ID, virtual address, length, size, burst, drop, physical address
        set_row(0, "burst4_first", 'h11, 'h0000_1000, 3,  2, 1, 0, 'h8000_1000);
        set_row(1, "single_beat",  'h12, 'h0000_2004, 0,  2, 1, 0, 'h8000_2004);
        set_row(2, "drop_between", 'h13, 'h0000_3000, 2,  2, 1, 1, 'h0);
        set_row(3, "burst8_incr",  'h14, 'h0000_4000, 7,  2, 1, 0, 'h8004_4000);
        set_row(4, "fixed_burst",  'h15, 'h0000_5000, 1,  2, 0, 0, 'h8005_5000);
        set_row(5, "drop_single",  'h16, 'h0000_6000, 0,  2, 1, 1, 'h0);
        set_row(6, "wrap_burst",   'h17, 'h0000_7000, 3,  2, 2, 0, 'h8007_7000);
        set_row(7, "long_burst",   'h18, 'h0000_8000, 15, 2, 1, 0, 'h8008_8000);
        set_row(8, "byte_beats",   'h19, 'h0000_9001, 4,  0, 1, 0, 'h8009_9001);
        set_row(9, "drop_long",    'h1a, 'h0000_a000, 5,  2, 1, 1, 'h0);
    endtask

`endif

//--- sim/tb_axi_mmu_rd.sv
`timescale 1ns/1ps

module tb_axi_mmu_rd;

    import axi_pkg::*;
    import mmu_pkg::*;

    localparam int          AR_FIFO_DEPTH = 8;
    localparam logic [31:0] SEED          = 32'h2d64;

    logic                       s_axi_clk;
    logic                       s_aresetn;
    logic [AXI_ID_WIDTH-1:0]    s_axi_arid;
    logic [AXI_ADDR_WIDTH-1:0]  s_axi_araddr;
    logic [AXI_LEN_WIDTH-1:0]   s_axi_arlen;
    logic [AXI_SIZE_WIDTH-1:0]  s_axi_arsize;
    logic [AXI_BURST_WIDTH-1:0] s_axi_arburst;
    logic                       s_axi_arvalid;
    logic                       s_axi_arready;
    logic [AXI_ID_WIDTH-1:0]    s_axi_rid;
    logic [AXI_DATA_WIDTH-1:0]  s_axi_rdata;
    logic [AXI_RESP_WIDTH-1:0]  s_axi_rresp;
    logic                       s_axi_rlast;
    logic                       s_axi_rvalid;
    logic                       s_axi_rready;
    logic [AXI_ID_WIDTH-1:0]    m_axi_arid;
    logic [AXI_ADDR_WIDTH-1:0]  m_axi_araddr;
    logic [AXI_LEN_WIDTH-1:0]   m_axi_arlen;
    logic [AXI_SIZE_WIDTH-1:0]  m_axi_arsize;
    logic [AXI_BURST_WIDTH-1:0] m_axi_arburst;
    logic                       m_axi_arvalid;
    logic                       m_axi_arready;
    logic [AXI_ID_WIDTH-1:0]    m_axi_rid;
    logic [AXI_DATA_WIDTH-1:0]  m_axi_rdata;
    logic [AXI_RESP_WIDTH-1:0]  m_axi_rresp;
    logic                       m_axi_rlast;
    logic                       m_axi_rvalid;
    logic                       m_axi_rready;
    logic [MMU_REQ_WIDTH-1:0]   to_mmu_tdata;
    logic                       to_mmu_tvalid;
    logic                       to_mmu_tready;
    logic [MMU_RSP_WIDTH-1:0]   from_mmu_tdata;
    logic                       from_mmu_tvalid;
    logic                       from_mmu_tready;

    `include "tb_vectors.svh"

    // Rows translated to a real read and queued in the order the memory
    // should see their AR
    int issued_q [$];
    int mmu_idx;
    int r_idx;
    int r_beat;
    bit saw_ar_stall;

    axi_mmu_rd_top #(.AR_FIFO_DEPTH(AR_FIFO_DEPTH)) UUT (.*);

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string test, input string field,
                                   input logic [63:0] expected, input logic [63:0] actual);
        $display("FAIL %s %s: expected 0x%0h actual 0x%0h", test, field, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_with_failure();
    endtask

    function automatic int max_table_len();
        int longest;
        longest = 0;
        for (int i = 0; i < NUM_VECS; i++) begin
            if (vec_len[i] > longest) longest = vec_len[i];
        end
        return longest;
    endfunction

    initial begin
        s_axi_clk = 1'b0;
        forever #5 s_axi_clk = ~s_axi_clk;
    end

    initial begin : main_sequence
        void'($urandom(SEED));
        load_table();
        s_aresetn     = 1'b0;
        s_axi_arid    = '0;
        s_axi_araddr  = '0;
        s_axi_arlen   = '0;
        s_axi_arsize  = '0;
        s_axi_arburst = '0;
        s_axi_arvalid = 1'b0;
        saw_ar_stall  = 1'b0;
        repeat (2) @(posedge s_axi_clk);
        s_aresetn <= 1'b1;
        @(posedge s_axi_clk);
        assert (!to_mmu_tvalid) else report_mismatch("reset", "to_mmu_tvalid", 0, to_mmu_tvalid);
        assert (!m_axi_arvalid) else report_mismatch("reset", "m_axi_arvalid", 0, m_axi_arvalid);
        assert (!s_axi_rvalid) else report_mismatch("reset", "s_axi_rvalid", 0, s_axi_rvalid);
        assert (s_axi_arready) else report_mismatch("reset", "s_axi_arready", 1, s_axi_arready);
        // All rows go out back to back and the FIFO stalls the channel when full
        for (int i = 0; i < NUM_VECS; i++) begin
            s_axi_arvalid <= 1'b1;
            s_axi_arid    <= vec_id[i];
            s_axi_araddr  <= vec_vaddr[i];
            s_axi_arlen   <= vec_len[i];
            s_axi_arsize  <= vec_size[i];
            s_axi_arburst <= vec_burst[i];
            @(posedge s_axi_clk);
            while (!s_axi_arready) begin
                saw_ar_stall = 1'b1;
                @(posedge s_axi_clk);
            end
        end
        s_axi_arvalid <= 1'b0;
        wait (r_idx == NUM_VECS);
        @(posedge s_axi_clk);
        assert (mmu_idx == NUM_VECS)
            else report_mismatch("end_of_run", "mmu requests", NUM_VECS, mmu_idx);
        assert (saw_ar_stall)
            else report_problem("The read-address channel never stalled, the FIFO did not fill");
        $display("Finished with no errors");
        $finish;
    end

    initial begin : master_ready
        s_axi_rready = 1'b0;
        forever begin
            @(posedge s_axi_clk);
            s_axi_rready <= ($urandom_range(3, 0) != 0);
        end
    end

    initial begin : mmu_model
        logic [MMU_REQ_WIDTH-1:0] exp_req;
        int delay;
        to_mmu_tready   = 1'b1;
        from_mmu_tdata  = '0;
        from_mmu_tvalid = 1'b0;
        mmu_idx         = 0;
        forever begin
            @(posedge s_axi_clk);
            if (s_aresetn && to_mmu_tvalid && to_mmu_tready) begin
                assert (mmu_idx < NUM_VECS)
                    else report_problem("MMU request seen after every row was translated");
                // Padding, size, length, ID and virtual address from the top bit down
                exp_req = {5'd0, vec_size[mmu_idx], vec_len[mmu_idx], vec_id[mmu_idx],
                           vec_vaddr[mmu_idx]};
                assert (to_mmu_tdata == exp_req)
                    else report_mismatch(vec_name[mmu_idx], "mmu request", exp_req, to_mmu_tdata);
                delay = $urandom_range(3, 0);
                repeat (delay) @(posedge s_axi_clk);
                from_mmu_tvalid <= 1'b1;
                from_mmu_tdata  <= {7'd0, vec_drop[mmu_idx],
                                    vec_drop[mmu_idx] ? 32'h0 : vec_paddr[mmu_idx]};
                if (!vec_drop[mmu_idx]) issued_q.push_back(mmu_idx);
                @(posedge s_axi_clk);
                while (!from_mmu_tready) @(posedge s_axi_clk);
                from_mmu_tvalid <= 1'b0;
                mmu_idx++;
            end
        end
    end

    initial begin : memory_model
        logic [AXI_ID_WIDTH-1:0]   ar_id;
        logic [AXI_ADDR_WIDTH-1:0] ar_addr;
        logic [AXI_LEN_WIDTH-1:0]  ar_len;
        int row;
        int delay;
        m_axi_arready = 1'b0;
        m_axi_rid     = '0;
        m_axi_rdata   = '0;
        m_axi_rresp   = '0;
        m_axi_rlast   = 1'b0;
        m_axi_rvalid  = 1'b0;
        forever begin
            @(posedge s_axi_clk);
            if (s_aresetn && m_axi_arvalid) begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(posedge s_axi_clk);
                m_axi_arready <= 1'b1;
                @(posedge s_axi_clk);
                m_axi_arready <= 1'b0;
                assert (issued_q.size() != 0)
                    else report_problem("Memory read address seen for a dropped or unknown read");
                row = issued_q.pop_front();
                assert (m_axi_araddr == vec_paddr[row])
                    else report_mismatch(vec_name[row], "araddr", vec_paddr[row], m_axi_araddr);
                assert (m_axi_arid == vec_id[row])
                    else report_mismatch(vec_name[row], "arid", vec_id[row], m_axi_arid);
                assert (m_axi_arlen == vec_len[row])
                    else report_mismatch(vec_name[row], "arlen", vec_len[row], m_axi_arlen);
                assert (m_axi_arsize == vec_size[row])
                    else report_mismatch(vec_name[row], "arsize", vec_size[row], m_axi_arsize);
                assert (m_axi_arburst == vec_burst[row])
                    else report_mismatch(vec_name[row], "arburst", vec_burst[row], m_axi_arburst);
                ar_id   = m_axi_arid;
                ar_addr = m_axi_araddr;
                ar_len  = m_axi_arlen;
                for (int beat = 0; beat <= ar_len; beat++) begin
                    m_axi_rvalid <= 1'b1;
                    m_axi_rid    <= ar_id;
                    m_axi_rdata  <= ar_addr + beat;
                    m_axi_rresp  <= AXI_RESP_OKAY;
                    m_axi_rlast  <= (beat == ar_len);
                    @(posedge s_axi_clk);
                    while (!m_axi_rready) @(posedge s_axi_clk);
                end
                m_axi_rvalid <= 1'b0;
                m_axi_rlast  <= 1'b0;
            end
        end
    end

    initial begin : read_checker
        logic [AXI_DATA_WIDTH-1:0] exp_data;
        logic [AXI_RESP_WIDTH-1:0] exp_resp;
        logic                      exp_last;
        r_idx  = 0;
        r_beat = 0;
        forever begin
            @(posedge s_axi_clk);
            if (s_aresetn && s_axi_rvalid && s_axi_rready) begin
                assert (r_idx < NUM_VECS)
                    else report_problem("Read data beat arrived after every row had completed");
                exp_data = vec_drop[r_idx] ? '0 : vec_paddr[r_idx] + r_beat;
                exp_resp = vec_drop[r_idx] ? AXI_RESP_DECERR : AXI_RESP_OKAY;
                exp_last = (r_beat == vec_len[r_idx]);
                assert (s_axi_rid == vec_id[r_idx])
                    else report_mismatch(vec_name[r_idx], "rid", vec_id[r_idx], s_axi_rid);
                assert (s_axi_rdata == exp_data)
                    else report_mismatch(vec_name[r_idx], "rdata", exp_data, s_axi_rdata);
                assert (s_axi_rresp == exp_resp)
                    else report_mismatch(vec_name[r_idx], "rresp", exp_resp, s_axi_rresp);
                assert (s_axi_rlast == exp_last)
                    else report_mismatch(vec_name[r_idx], "rlast", exp_last, s_axi_rlast);
                if (exp_last) begin
                    r_idx++;
                    r_beat = 0;
                end else begin
                    r_beat++;
                end
            end
        end
    end

    // Budget per row covers the longest burst plus translation overhead
    initial begin : watchdog
        int limit;
        #1;
        limit = NUM_VECS * (max_table_len() + 1 + 30);
        repeat (limit) @(posedge s_axi_clk);
        report_problem($sformatf("Timeout after %0d cycles with %0d of %0d rows completed",
                                 limit, r_idx, NUM_VECS));
    end

endmodule

//--- compile.f
+incdir+sim
common/axi_pkg.sv
common/mmu_pkg.sv
ar_path/ar_request_fifo.sv
ar_path/ar_translate_ctrl.sv
hdl/r_return.sv
hdl/axi_mmu_rd_top.sv
sim/tb_axi_mmu_rd.sv
